/* common/socPkg.sv */
`default_nettype none

package socPkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	// Byte address on the data bus
	typedef logic [31:0] addrT;
	// Data word on the data bus
	typedef logic [31:0] dataT;
	// Write byte enables, zero means read
	typedef logic [3:0] byteMaskT;
	// Word index into program memory
	typedef logic [11:0] memIdxT;
	// Register index inside the I/O block
	typedef logic [1:0] ioOffT;
	// Board LEDs
	typedef logic [7:0] ledT;
	// Board switches
	typedef logic [15:0] swT;

	////////////////////////////////////////////////////////////
	// Bus transfer structs
	////////////////////////////////////////////////////////////

	typedef struct packed {
		addrT addr;
		dataT wdata;
		byteMaskT mask;
	} busReqT;

	typedef struct packed {
		dataT rdata;
		logic err;
	} busRspT;

	// Decoded target of one access
	typedef enum logic [1:0] {
		selMem,
		selIo,
		selNone
	} devSelT;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////

	// Program memory, 4096 words
	localparam addrT memBase = 32'h0000_0000;
	localparam addrT memSize = 32'h0000_4000;

	// I/O block, four word registers
	localparam addrT ioBase = 32'h0001_0000;
	localparam addrT ioSize = 32'h0000_0010;

	// Register indices inside the I/O block
	localparam ioOffT ioLedOff = 2'd0;
	localparam ioOffT ioSwOff = 2'd1;
	localparam ioOffT ioReloadOff = 2'd2;
	localparam ioOffT ioCtrlOff = 2'd3;

	// Read word of an unmapped access
	localparam dataT errData = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

/* rtl/cpuBus.sv */
`default_nettype none

module cpuBus (
	input wire logic clkCPU,
	input wire logic rstN,
	input wire logic reqValid,
	output logic reqReady,
	input wire socPkg::busReqT req,
	output logic rspValid,
	input wire logic rspReady,
	output socPkg::busRspT rsp,
	output logic memEn,
	output socPkg::memIdxT memIdx,
	output logic ioEn,
	output socPkg::ioOffT ioOff,
	output socPkg::dataT wdata,
	output socPkg::byteMaskT mask,
	input wire socPkg::dataT memRdata,
	input wire socPkg::dataT ioRdata
);
	import socPkg::*;

	typedef enum logic {
		stIdle,
		stRespond
	} busStateT;

	busStateT state;
	devSelT decSel;
	devSelT selQ;
	logic accept;
	// High in the first respond cycle only
	logic freshQ;
	busRspT rspMux;
	busRspT rspHold;

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	assign reqReady = (state == stIdle);
	assign accept = reqValid && reqReady;

	// Offset compare keeps the decode free of base assumptions
	always_comb begin
		if ((req.addr - memBase) < memSize)
			decSel = selMem;
		else if ((req.addr - ioBase) < ioSize)
			decSel = selIo;
		else
			decSel = selNone;
	end

	// One strobe per accepted mapped access
	assign memEn = accept && (decSel == selMem);
	assign ioEn = accept && (decSel == selIo);
	// Word address bits
	assign memIdx = req.addr[2 +: $bits(memIdxT)];
	assign ioOff = req.addr[2 +: $bits(ioOffT)];
	assign wdata = req.wdata;
	assign mask = req.mask;

	always_ff @(posedge clkCPU) begin
		if (!rstN) begin
			state <= stIdle;
			selQ <= selNone;
			freshQ <= 1'b0;
		end else begin
			case (state)
				stIdle: begin
					if (reqValid) begin
						state <= stRespond;
						selQ <= decSel;
						freshQ <= 1'b1;
					end
				end
				stRespond: begin
					freshQ <= 1'b0;
					if (rspReady)
						state <= stIdle;
				end
				default: state <= stIdle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Response side
	////////////////////////////////////////////////////////////

	// Devices return their word one cycle after the strobe
	always_comb begin
		case (selQ)
			selMem: rspMux = '{rdata: memRdata, err: 1'b0};
			selIo: rspMux = '{rdata: ioRdata, err: 1'b0};
			default: rspMux = '{rdata: errData, err: 1'b1};
		endcase
	end

	// Capture once, then hold while the master stalls
	always_ff @(posedge clkCPU) begin
		if (freshQ)
			rspHold <= rspMux;
	end

	assign rspValid = (state == stRespond);
	assign rsp = freshQ ? rspMux : rspHold;

	// Stalled response must not move
	assert property (@(posedge clkCPU) disable iff (!rstN)
		rspValid && !rspReady |=> rspValid && $stable(rsp));

	// At most one device strobed
	assert property (@(posedge clkCPU) disable iff (!rstN) !(memEn && ioEn));

endmodule

`default_nettype wire

/* rtl/biosMem.sv */
`default_nettype none

module biosMem (
	input wire logic clkCPU,
	input wire logic en,
	input wire socPkg::memIdxT idx,
	input wire socPkg::dataT wdata,
	input wire socPkg::byteMaskT mask,
	output socPkg::dataT rdata
);
	import socPkg::*;

	// Word count from the map
	localparam int depth = int'(memSize) / 4;
	localparam int nBytes = $bits(byteMaskT);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	dataT mem [depth];

	// Read and write share one port
	// Old word is returned on a write
	always_ff @(posedge clkCPU) begin
		if (en) begin
			rdata <= mem[idx];
			for (int b = 0; b < nBytes; b++) begin
				// Only enabled lanes change
				if (mask[b])
					mem[idx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

	// rdata holds between strobes
	// Bus relies on that while a response stalls

	// No reset on the array
	// Contents are undefined until written

endmodule

`default_nettype wire

/* ioDevice/ioRegs.sv */
`default_nettype none

module ioRegs (
	input wire logic clkCPU,
	input wire logic rstN,
	input wire logic en,
	input wire socPkg::ioOffT off,
	input wire socPkg::dataT wdata,
	input wire socPkg::byteMaskT mask,
	output socPkg::dataT rdata,
	input wire socPkg::swT sw,
	output socPkg::ledT led,
	output logic timerEn,
	output socPkg::dataT timerReload,
	output logic irqClear,
	input wire logic expire,
	input wire socPkg::dataT count,
	output logic irq
);
	import socPkg::*;

	ledT ledQ;
	swT swQ;
	dataT reloadQ;
	logic enQ;
	logic pendQ;
	logic wrLed;
	logic wrReload;
	logic wrCtrl;

	// Register selects
	assign wrLed = en && (off == ioLedOff);
	assign wrReload = en && (off == ioReloadOff);
	assign wrCtrl = en && (off == ioCtrlOff);

	// Write 1 to ctrl bit 1 acks the interrupt
	assign irqClear = wrCtrl && mask[0] && wdata[1];

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clkCPU) begin
		if (!rstN) begin
			ledQ <= '0;
			reloadQ <= '0;
			enQ <= 1'b0;
			pendQ <= 1'b0;
		end else begin
			if (wrLed && mask[0])
				ledQ <= wdata[7:0];
			// Reload written lane by lane
			for (int b = 0; b < $bits(byteMaskT); b++) begin
				if (wrReload && mask[b])
					reloadQ[8*b +: 8] <= wdata[8*b +: 8];
			end
			if (wrCtrl && mask[0])
				enQ <= wdata[0];
			// Expire beats a simultaneous clear
			if (expire)
				pendQ <= 1'b1;
			else if (irqClear)
				pendQ <= 1'b0;
		end
	end

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////

	// Switch sampling stage
	always_ff @(posedge clkCPU) begin
		swQ <= sw;
	end

	// Word latched on the strobe, values before any write
	always_ff @(posedge clkCPU) begin
		if (en) begin
			case (off)
				ioLedOff: rdata <= dataT'(ledQ);
				ioSwOff: rdata <= dataT'(swQ);
				ioReloadOff: rdata <= reloadQ;
				default: rdata <= {count[15:0], 14'b0, pendQ, enQ};
			endcase
		end
	end

	assign led = ledQ;
	assign timerEn = enQ;
	assign timerReload = reloadQ;
	assign irq = pendQ;

endmodule

`default_nettype wire

/* ioDevice/ioTimer.sv */
`default_nettype none

module ioTimer (
	input wire logic clkCPU,
	input wire logic rstN,
	input wire logic timerEn,
	input wire socPkg::dataT timerReload,
	output socPkg::dataT count,
	output logic expire
);
	import socPkg::*;

	dataT countQ;
	dataT curCount;
	logic enPrev;
	logic startEdge;

	// First cycle after enable goes high
	assign startEdge = timerEn && !enPrev;

	// Fresh start sees the reload value as if loaded with the write
	assign curCount = startEdge ? timerReload : countQ;

	// Fires in the cycle the count sits at zero
	assign expire = timerEn && (curCount == '0);

	////////////////////////////////////////////////////////////
	// Counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clkCPU) begin
		if (!rstN) begin
			enPrev <= 1'b0;
			countQ <= '0;
		end else begin
			enPrev <= timerEn;
			// Disabled timer holds its value
			if (expire)
				countQ <= timerReload;
			else if (timerEn)
				countQ <= curCount - 1'b1;
		end
	end

	assign count = curCount;

	// Never fires while stopped
	assert property (@(posedge clkCPU) disable iff (!rstN) expire |-> timerEn);

endmodule

`default_nettype wire

/* rtl/socTop.sv */
`default_nettype none

module socTop (
	input wire logic clkCPU,
	input wire logic rstN,
	input wire logic reqValid,
	output logic reqReady,
	input wire socPkg::busReqT req,
	output logic rspValid,
	input wire logic rspReady,
	output socPkg::busRspT rsp,
	input wire socPkg::swT sw,
	output socPkg::ledT led,
	output logic irq
);
	import socPkg::*;

	////////////////////////////////////////////////////////////
	// Device side of the data bus
	////////////////////////////////////////////////////////////

	logic memEn;
	logic ioEn;
	memIdxT memIdx;
	ioOffT ioOff;
	dataT busWdata;
	byteMaskT busMask;
	dataT memRdata;
	dataT ioRdata;

	// Timer control
	logic timerEn;
	logic expire;
	dataT timerReload;
	dataT count;

	cpuBus bus0 (
		.clkCPU(clkCPU), .rstN(rstN),
		.reqValid(reqValid), .reqReady(reqReady), .req(req),
		.rspValid(rspValid), .rspReady(rspReady), .rsp(rsp),
		.memEn(memEn), .memIdx(memIdx), .ioEn(ioEn), .ioOff(ioOff),
		.wdata(busWdata), .mask(busMask),
		.memRdata(memRdata), .ioRdata(ioRdata)
	);

	biosMem mem0 (
		.clkCPU(clkCPU), .en(memEn), .idx(memIdx),
		.wdata(busWdata), .mask(busMask), .rdata(memRdata)
	);

	// Register block steering the timer
	ioRegs io0 (
		.clkCPU(clkCPU), .rstN(rstN), .en(ioEn), .off(ioOff),
		.wdata(busWdata), .mask(busMask), .rdata(ioRdata),
		.sw(sw), .led(led),
		.timerEn(timerEn), .timerReload(timerReload), .irqClear(),
		.expire(expire), .count(count), .irq(irq)
	);

	ioTimer timer0 (
		.clkCPU(clkCPU), .rstN(rstN),
		.timerEn(timerEn), .timerReload(timerReload),
		.count(count), .expire(expire)
	);

endmodule

`default_nettype wire

/* verif/clkGen.sv */
`default_nettype none

module clkGen #(
	parameter int period = 8,
	parameter int resetCycles = 2
) (
	output logic clk,
	output logic rstN
);

	// Free running clock
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// Reset released just after the last reset edge
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1;
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/socTb.sv */
`default_nettype none

module socTb;
	import socPkg::*;

	localparam int timeoutCycles = 200;
	// Memory words exercised by the random tests
	localparam int winWords = 32;

	logic clkCPU;
	logic rstN;
	logic reqValid;
	logic reqReady;
	busReqT req;
	logic rspValid;
	logic rspReady;
	busRspT rsp;
	swT sw;
	ledT led;
	logic irq;

	// Reference state
	dataT refMem [4096];
	bit refKnown [4096];
	ledT refLed;
	dataT refReload;

	// Predicted responses in issue order
	busRspT expRspQ [$];
	bit expKnownQ [$];

	logic [31:0] rngState;
	int cycleCnt = 0;
	int acceptCycle;
	int errCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int failedTests = 0;
	int testErrStart;
	string testName;

	clkGen #(.period(8), .resetCycles(2)) clkGen_i (.clk(clkCPU), .rstN(rstN));

	socTop socTop_i (
		.clkCPU(clkCPU), .rstN(rstN),
		.reqValid(reqValid), .reqReady(reqReady), .req(req),
		.rspValid(rspValid), .rspReady(rspReady), .rsp(rsp),
		.sw(sw), .led(led), .irq(irq)
	);

	always @(posedge clkCPU) cycleCnt <= cycleCnt + 1;

	////////////////////////////////////////////////////////////
	// Random numbers and reference model
	////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] randWord();
		rngState = xorshift32(rngState);
		return rngState;
	endfunction

	// Expected response of one access, model then takes the write
	function automatic busRspT refAccess(input busReqT r, output bit known);
		busRspT e;
		int idx;
		e.rdata = '0;
		e.err = 1'b0;
		known = 1'b1;
		if (r.addr < 32'h0000_4000) begin
			idx = int'(r.addr[13:2]);
			// Old word comes back on a write
			e.rdata = refMem[idx];
			known = refKnown[idx];
			for (int b = 0; b < 4; b++) begin
				if (r.mask[b])
					refMem[idx][8*b +: 8] = r.wdata[8*b +: 8];
			end
			if (r.mask == 4'hF)
				refKnown[idx] = 1'b1;
		end else if (r.addr >= 32'h0001_0000 && r.addr < 32'h0001_0010) begin
			case (r.addr[3:2])
				2'd0: e.rdata = {24'b0, refLed};
				2'd1: e.rdata = {16'b0, sw};
				2'd2: e.rdata = refReload;
				// Control word carries the running count
				default: known = 1'b0;
			endcase
			if (r.addr[3:2] == 2'd0 && r.mask[0])
				refLed = r.wdata[7:0];
			for (int b = 0; b < 4; b++) begin
				if (r.addr[3:2] == 2'd2 && r.mask[b])
					refReload[8*b +: 8] = r.wdata[8*b +: 8];
			end
		end else begin
			e.rdata = 32'hDEAD_BEEF;
			e.err = 1'b1;
		end
		return e;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic checkRsp(input busRspT got, input busRspT exp, input bit known,
			input string what);
		checkCount++;
		if (got.err !== exp.err || (known && got.rdata !== exp.rdata)) begin
			errCount++;
			$display("Mismatch at %0t: %s got %h/%b, expected %h/%b", $time, what,
				got.rdata, got.err, exp.rdata, exp.err);
		end
	endtask

	task automatic checkLed(input ledT got, input ledT exp);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Mismatch at %0t: led is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic checkIrq(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Handshake flags
	task automatic checkFlag(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// Latencies in clock cycles
	task automatic checkDelay(input int got, input int exp, input string what);
		checkCount++;
		if (got != exp) begin
			errCount++;
			$display("Mismatch at %0t: %s is %0d cycles, expected %0d", $time, what, got, exp);
		end
	endtask

	// Every completed response against its prediction
	always @(negedge clkCPU) begin
		busRspT expRsp;
		bit expKnown;
		if (rstN === 1'b1 && rspValid === 1'b1 && rspReady === 1'b1) begin
			if (expRspQ.size() == 0) begin
				errCount++;
				$display("Response at %0t arrived with no request outstanding", $time);
			end else begin
				expRsp = expRspQ.pop_front();
				expKnown = expKnownQ.pop_front();
				checkRsp(rsp, expRsp, expKnown, "response");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	task automatic abortRun(input string what);
		$display("Timeout at %0t: %s", $time, what);
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errCount);
		$display("Done: errors found");
		$finish;
	endtask

	// Inputs change just after the edge
	task automatic waitCycle();
		@(posedge clkCPU);
		#1;
	endtask

	// One transaction, rspReady held low for stall cycles
	task automatic busXfer(input busReqT r, input int stall);
		int waited;
		busRspT held;
		req = r;
		reqValid = 1'b1;
		waited = 0;
		while (reqReady !== 1'b1) begin
			if (waited >= timeoutCycles)
				abortRun("the request handshake never completed");
			waitCycle();
			waited++;
		end
		// Accepting edge
		waitCycle();
		acceptCycle = cycleCnt;
		reqValid = 1'b0;
		waited = 0;
		while (rspValid !== 1'b1) begin
			if (waited >= timeoutCycles)
				abortRun("the response never arrived");
			waitCycle();
			waited++;
		end
		checkDelay(cycleCnt - acceptCycle, 0, "extra response wait");
		checkFlag(reqReady, 1'b0, "reqReady while busy");
		held = rsp;
		for (int i = 0; i < stall; i++) begin
			waitCycle();
			checkFlag(rspValid, 1'b1, "rspValid during stall");
			checkFlag(reqReady, 1'b0, "reqReady during stall");
			checkRsp(rsp, held, 1'b1, "rsp during stall");
		end
		rspReady = 1'b1;
		waitCycle();
		rspReady = 1'b0;
		checkFlag(rspValid, 1'b0, "rspValid after handshake");
		checkFlag(reqReady, 1'b1, "reqReady after handshake");
	endtask

	task automatic sendRequest(input busReqT r, input int stall);
		busRspT e;
		bit known;
		e = refAccess(r, known);
		expRspQ.push_back(e);
		expKnownQ.push_back(known);
		busXfer(r, stall);
	endtask

	task automatic busWrite(input addrT a, input dataT d, input byteMaskT m, input int stall);
		sendRequest('{addr: a, wdata: d, mask: m}, stall);
	endtask

	task automatic busRead(input addrT a, input int stall);
		sendRequest('{addr: a, wdata: randWord(), mask: 4'h0}, stall);
	endtask

	task automatic waitIrqHigh();
		int waited;
		waited = 0;
		while (irq !== 1'b1) begin
			if (waited >= timeoutCycles)
				abortRun("the timer interrupt never rose");
			waitCycle();
			waited++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrStart = errCount;
		testCount++;
	endtask

	task automatic endTest();
		if (errCount == testErrStart) begin
			$display("Test %0d %s: ok", testCount, testName);
		end else begin
			failedTests++;
			$display("Test %0d %s: FAILED with %0d errors", testCount, testName,
				errCount - testErrStart);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		addrT a;
		logic [31:0] r;
		int winBase;
		int startCyc;
		int waited;
		dataT reloadVal;
		reqValid = 1'b0;
		req = '0;
		rspReady = 1'b0;
		sw = '0;
		rngState = 32'h67a78269;
		refLed = '0;
		refReload = '0;
		waited = 0;
		while (rstN !== 1'b1) begin
			if (waited >= timeoutCycles)
				abortRun("reset was never released");
			waitCycle();
			waited++;
		end
		waitCycle();

		startTest("reset state");
		checkFlag(reqReady, 1'b1, "reqReady after reset");
		checkFlag(rspValid, 1'b0, "rspValid after reset");
		checkIrq(irq, 1'b0, "irq after reset");
		checkLed(led, '0);
		endTest();

		// Window at a random spot in memory
		startTest("memory random access");
		winBase = int'(randWord() % (4096 - winWords));
		for (int i = 0; i < winWords; i++)
			busWrite(addrT'((winBase + i) * 4), randWord(), 4'hF, 0);
		for (int i = 0; i < 200; i++) begin
			r = randWord();
			a = addrT'((winBase + int'(r[12:8]) % winWords) * 4);
			if (r[0])
				busWrite(a, randWord(), r[7:4], 0);
			else
				busRead(a, 0);
		end
		endTest();

		startTest("LED and switch registers");
		for (int i = 0; i < 8; i++) begin
			r = randWord();
			busWrite(32'h0001_0000, randWord(), r[3:0], 0);
			checkLed(led, refLed);
			busRead(32'h0001_0000, 0);
			sw = r[31:16];
			// Switch sampling stage settles
			repeat (2) waitCycle();
			busRead(32'h0001_0004, 0);
			busWrite(32'h0001_0008, randWord(), r[7:4], 0);
			busRead(32'h0001_0008, 0);
		end
		endTest();

		startTest("unmapped accesses");
		for (int i = 0; i < 16; i++) begin
			r = randWord();
			a = randWord();
			if (a < 32'h0000_4000 || (a >= 32'h0001_0000 && a < 32'h0001_0010))
				a = a + 32'h0002_0000;
			busWrite(a, randWord(), r[3:0], 0);
		end
		// Aliases of the window and the register block
		busWrite(addrT'(32'h0000_4000 + winBase * 4), randWord(), 4'hF, 0);
		busWrite(32'h0001_0010, randWord(), 4'hF, 0);
		busRead(32'hFFFF_FFFC, 0);
		for (int i = 0; i < winWords; i++)
			busRead(addrT'((winBase + i) * 4), 0);
		busRead(32'h0001_0000, 0);
		busRead(32'h0001_0008, 0);
		checkLed(led, refLed);
		endTest();

		startTest("response back-pressure");
		for (int i = 0; i < 24; i++) begin
			r = randWord();
			a = r[4] ? 32'h0001_0000 : addrT'((winBase + int'(r[12:8]) % winWords) * 4);
			if (r[0])
				busWrite(a, randWord(), r[7:4], int'(r[18:16]) + 1);
			else
				busRead(a, int'(r[18:16]) + 1);
		end
		endTest();

		startTest("timer interrupt");
		reloadVal = randWord() % 24 + 2;
		busWrite(32'h0001_0008, reloadVal, 4'hF, 0);
		checkIrq(irq, 1'b0, "irq before enable");
		busWrite(32'h0001_000C, 32'h1, 4'h1, 0);
		startCyc = acceptCycle;
		waitIrqHigh();
		checkDelay(cycleCnt - startCyc, int'(reloadVal) + 1, "irq delay after enable");
		// Pending stays until acknowledged
		for (int i = 0; i < 2 * (int'(reloadVal) + 1); i++) begin
			waitCycle();
			checkIrq(irq, 1'b1, "irq while pending");
		end
		// Stop, then acknowledge and restart in one write
		busWrite(32'h0001_000C, 32'h0, 4'h1, 0);
		busWrite(32'h0001_000C, 32'h3, 4'h1, 0);
		startCyc = acceptCycle;
		checkIrq(irq, 1'b0, "irq after clear");
		waitIrqHigh();
		checkDelay(cycleCnt - startCyc, int'(reloadVal) + 1, "irq delay after clear");
		busWrite(32'h0001_000C, 32'h2, 4'h1, 0);
		endTest();

		if (expRspQ.size() != 0) begin
			errCount++;
			$display("%0d predicted responses were never seen", expRspQ.size());
		end
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			testCount, failedTests, checkCount, errCount);
		if (errCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
common/socPkg.sv
rtl/cpuBus.sv
rtl/biosMem.sv
ioDevice/ioRegs.sv
ioDevice/ioTimer.sv
rtl/socTop.sv
verif/clkGen.sv
verif/socTb.sv

/* Makefile */
# Verilator build of the data-bus testbench

SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := socTb
FILELIST := sources.f

OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJDIR)
